// File: design/digdar_pkg.sv
// shared bus widths, region map, register offsets and state enums
`default_nettype none

package digdar_pkg;

   //-------------------------------------------------------------------------
   // bus
   localparam int SYS_AW     = 32;           // address width
   localparam int SYS_DW     = 32;           // data width
   localparam int REGION_MSB = 22;           // region select field
   localparam int REGION_LSB = 20;

   typedef enum logic [2:0] {
      region_hk     = 3'd0,                  // housekeeping
      region_scope  = 3'd1,                  // scope and capture buffer
      region_digdar = 3'd6                   // radar trigger
   } region_e;                               // other codes are unmapped

   localparam logic [SYS_DW-1:0] HK_ID_VALUE = 32'hd16d_0a01;

   //-------------------------------------------------------------------------
   // register offsets inside a region
   localparam logic [REGION_LSB-1:0] HK_OFS_ID       = 20'h00000;
   localparam logic [REGION_LSB-1:0] HK_OFS_LED      = 20'h00004;
   localparam logic [REGION_LSB-1:0] SC_OFS_CTRL     = 20'h00000;
   localparam logic [REGION_LSB-1:0] SC_OFS_COUNT    = 20'h00004;
   localparam logic [REGION_LSB-1:0] SC_OFS_NEGATE   = 20'h00008;
   localparam logic [REGION_LSB-1:0] SC_OFS_BUF      = 20'h10000;  // sample window base
   localparam logic [REGION_LSB-1:0] DD_OFS_THRESH   = 20'h00000;
   localparam logic [REGION_LSB-1:0] DD_OFS_DELAY    = 20'h00004;
   localparam logic [REGION_LSB-1:0] DD_OFS_TRIG_CNT = 20'h00008;

   //-------------------------------------------------------------------------
   // FSM states
   typedef enum logic [1:0] {sc_idle, sc_armed, sc_capture, sc_done} scope_state_e;
   typedef enum logic {tr_idle, tr_delay} trig_state_e;

endpackage

`default_nettype wire

// File: design/adc_frontend.sv
// adc_frontend: offset-binary to two's complement, optional channel-A negate
`timescale 1ns/10ps
`default_nettype none

module adc_frontend #(
   parameter int ADC_WIDTH = 14
) (
   input  wire                         adc_clk,
   input  wire                         rst_n_i,
   input  wire        [ADC_WIDTH-1:0]  adc_dat_a_i,   // offset binary
   input  wire        [ADC_WIDTH-1:0]  adc_dat_b_i,
   input  wire                         negate_i,      // invert channel A
   output logic signed [ADC_WIDTH-1:0] adc_a_o,       // two's complement, latency 1
   output logic signed [ADC_WIDTH-1:0] adc_b_o
);

   localparam logic signed [ADC_WIDTH-1:0] MOST_NEG = {1'b1, {(ADC_WIDTH-1){1'b0}}};
   localparam logic signed [ADC_WIDTH-1:0] MOST_POS = {1'b0, {(ADC_WIDTH-1){1'b1}}};

   logic signed [ADC_WIDTH-1:0] a_conv;
   logic signed [ADC_WIDTH-1:0] b_conv;
   logic signed [ADC_WIDTH-1:0] a_neg;

   assign a_conv = {~adc_dat_a_i[ADC_WIDTH-1], adc_dat_a_i[ADC_WIDTH-2:0]};  // flip msb
   assign b_conv = {~adc_dat_b_i[ADC_WIDTH-1], adc_dat_b_i[ADC_WIDTH-2:0]};

   // -MOST_NEG does not fit, clamp it to full scale
   assign a_neg = (a_conv == MOST_NEG) ? MOST_POS : -a_conv;

   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         adc_a_o <= '0;
         adc_b_o <= '0;
      end else begin
         adc_a_o <= negate_i ? a_neg : a_conv;
         adc_b_o <= b_conv;                           // trigger source
      end
   end

endmodule

`default_nettype wire

// File: design/sys_bus_decoder.sv
// sys_bus_decoder: region decode, enable fan-out, answer mux, unmapped error
`timescale 1ns/10ps
`default_nettype none

module sys_bus_decoder (
   input  wire                            adc_clk,
   input  wire                            rst_n_i,
   input  wire  [digdar_pkg::SYS_AW-1:0]  sys_addr_i,
   input  wire                            sys_wen_i,
   input  wire                            sys_ren_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  hk_rdata_i,
   input  wire                            hk_ack_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  sc_rdata_i,
   input  wire                            sc_ack_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  dd_rdata_i,
   input  wire                            dd_ack_i,
   output logic                           hk_wen_o,
   output logic                           hk_ren_o,
   output logic                           sc_wen_o,
   output logic                           sc_ren_o,
   output logic                           dd_wen_o,
   output logic                           dd_ren_o,
   output logic [digdar_pkg::SYS_DW-1:0]  sys_rdata_o,
   output logic                           sys_ack_o,
   output logic                           sys_err_o
);

   digdar_pkg::region_e region;                 // region of the current access
   digdar_pkg::region_e sel_q;                  // region that answers this cycle
   logic                unmapped_q;             // error ack pending

   assign region = digdar_pkg::region_e'(
                      sys_addr_i[digdar_pkg::REGION_MSB:digdar_pkg::REGION_LSB]);

   // address and wdata go to everyone, only the enables are steered
   assign hk_wen_o = sys_wen_i && (region == digdar_pkg::region_hk);
   assign hk_ren_o = sys_ren_i && (region == digdar_pkg::region_hk);
   assign sc_wen_o = sys_wen_i && (region == digdar_pkg::region_scope);
   assign sc_ren_o = sys_ren_i && (region == digdar_pkg::region_scope);
   assign dd_wen_o = sys_wen_i && (region == digdar_pkg::region_digdar);
   assign dd_ren_o = sys_ren_i && (region == digdar_pkg::region_digdar);

   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         sel_q      <= digdar_pkg::region_hk;
         unmapped_q <= 1'b0;
      end else begin
         if (sys_wen_i || sys_ren_i)
            sel_q <= region;                              // hold until next access
         unmapped_q <= (sys_wen_i || sys_ren_i) &&
                       !(hk_wen_o || hk_ren_o || sc_wen_o || sc_ren_o ||
                         dd_wen_o || dd_ren_o);
      end
   end

   //------------------------------------------------------------------------
   // every region answers one cycle after its enable
   always_comb begin
      sys_err_o = 1'b0;
      case (sel_q)
         digdar_pkg::region_hk: begin
            sys_rdata_o = hk_rdata_i;
            sys_ack_o   = hk_ack_i;
         end
         digdar_pkg::region_scope: begin
            sys_rdata_o = sc_rdata_i;
            sys_ack_o   = sc_ack_i;
         end
         digdar_pkg::region_digdar: begin
            sys_rdata_o = dd_rdata_i;
            sys_ack_o   = dd_ack_i;
         end
         default: begin                                   // no slave behind it
            sys_rdata_o = '0;
            sys_ack_o   = unmapped_q;
            sys_err_o   = unmapped_q;
         end
      endcase
   end

   // a slave must not answer an access it never saw
   a_ack_after_enable: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (hk_ack_i |-> $past(hk_wen_o || hk_ren_o)) and
      (sc_ack_i |-> $past(sc_wen_o || sc_ren_o)) and
      (dd_ack_i |-> $past(dd_wen_o || dd_ren_o)));

endmodule

`default_nettype wire

// File: design/hk_regs.sv
// hk_regs: housekeeping region with ID and LED registers
`timescale 1ns/10ps
`default_nettype none

module hk_regs (
   input  wire                            adc_clk,
   input  wire                            rst_n_i,
   input  wire  [digdar_pkg::SYS_AW-1:0]  sys_addr_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  sys_wdata_i,
   input  wire                            sys_wen_i,
   input  wire                            sys_ren_i,
   output logic [digdar_pkg::SYS_DW-1:0]  sys_rdata_o,
   output logic                           sys_ack_o,
   output logic [7:0]                     led_o          // straight from the register
);

   logic [digdar_pkg::REGION_LSB-1:0] ofs;

   assign ofs = sys_addr_i[digdar_pkg::REGION_LSB-1:0];  // offset inside region

   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         led_o     <= '0;
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i || sys_ren_i;            // one cycle, always
         if (sys_wen_i && ofs == digdar_pkg::HK_OFS_LED)
            led_o <= sys_wdata_i[7:0];
      end
   end

   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         case (ofs)
            digdar_pkg::HK_OFS_ID:  sys_rdata_o <= digdar_pkg::HK_ID_VALUE;
            digdar_pkg::HK_OFS_LED: sys_rdata_o <= {24'h0, led_o};
            default:                sys_rdata_o <= '0;   // hole in the map
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/radar_trigger.sv
// radar_trigger: channel-B threshold crossing, delay, trigger counter, registers
`timescale 1ns/10ps
`default_nettype none

module radar_trigger #(
   parameter int ADC_WIDTH = 14
) (
   input  wire                            adc_clk,
   input  wire                            rst_n_i,
   input  wire  signed [ADC_WIDTH-1:0]    adc_b_i,       // converted channel B
   input  wire                            armed_i,       // scope waiting for trigger
   input  wire  [digdar_pkg::SYS_AW-1:0]  sys_addr_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  sys_wdata_i,
   input  wire                            sys_wen_i,
   input  wire                            sys_ren_i,
   output logic                           trig_o,        // one-cycle pulse
   output logic [digdar_pkg::SYS_DW-1:0]  sys_rdata_o,
   output logic                           sys_ack_o
);

   logic [digdar_pkg::REGION_LSB-1:0] ofs;
   logic signed [ADC_WIDTH-1:0]       thresh_q;
   logic signed [ADC_WIDTH-1:0]       b_prev_q;         // last cycle's sample
   logic [31:0]                       delay_q;
   logic [31:0]                       dly_cnt_q;
   logic [31:0]                       trig_cnt_q;
   logic                              crossing;
   digdar_pkg::trig_state_e           state_q;

   assign ofs      = sys_addr_i[digdar_pkg::REGION_LSB-1:0];
   assign crossing = armed_i && (adc_b_i >= thresh_q) && (b_prev_q < thresh_q);
   assign trig_o   = (state_q == digdar_pkg::tr_delay) && (dly_cnt_q == '0);

   always_ff @(posedge adc_clk)
      b_prev_q <= adc_b_i;

   //------------------------------------------------------------------------
   // a crossing starts the delay and later crossings wait for the pulse
   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         state_q    <= digdar_pkg::tr_idle;
         dly_cnt_q  <= '0;
         trig_cnt_q <= '0;
      end else begin
         case (state_q)
            digdar_pkg::tr_idle:
               if (crossing) begin
                  state_q   <= digdar_pkg::tr_delay;
                  dly_cnt_q <= delay_q;
               end
            default:
               if (trig_o) begin
                  state_q    <= digdar_pkg::tr_idle;
                  trig_cnt_q <= trig_cnt_q + 32'd1;
               end else begin
                  dly_cnt_q  <= dly_cnt_q - 32'd1;
               end
         endcase
      end
   end

   // register region
   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         thresh_q  <= '0;
         delay_q   <= '0;
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i || sys_ren_i;
         if (sys_wen_i && ofs == digdar_pkg::DD_OFS_THRESH)
            thresh_q <= sys_wdata_i[ADC_WIDTH-1:0];
         if (sys_wen_i && ofs == digdar_pkg::DD_OFS_DELAY)
            delay_q <= sys_wdata_i;                       // in adc_clk cycles
      end
   end

   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         case (ofs)
            digdar_pkg::DD_OFS_THRESH:   sys_rdata_o <= thresh_q;  // sign-extended
            digdar_pkg::DD_OFS_DELAY:    sys_rdata_o <= delay_q;
            digdar_pkg::DD_OFS_TRIG_CNT: sys_rdata_o <= trig_cnt_q;
            default:                     sys_rdata_o <= '0;
         endcase
      end
   end

   // scope leaves armed only on this pulse, so armed holds through the delay
   a_trig_while_armed: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      trig_o |-> armed_i);

endmodule

`default_nettype wire

// File: design/scope_capture.sv
// scope_capture: arm/trigger/capture FSM, capture RAM, scope registers, readback
`timescale 1ns/10ps
`default_nettype none

module scope_capture #(
   parameter int ADC_WIDTH = 14,
   parameter int BUF_AW    = 10
) (
   input  wire                            adc_clk,
   input  wire                            rst_n_i,
   input  wire  signed [ADC_WIDTH-1:0]    adc_a_i,       // converted channel A
   input  wire                            trig_i,        // radar trigger pulse
   input  wire  [digdar_pkg::SYS_AW-1:0]  sys_addr_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  sys_wdata_i,
   input  wire                            sys_wen_i,
   input  wire                            sys_ren_i,
   output logic                           armed_o,
   output logic                           negate_o,      // to the frontend
   output logic [digdar_pkg::SYS_DW-1:0]  sys_rdata_o,
   output logic                           sys_ack_o
);

   localparam int DEPTH = 1 << BUF_AW;

   logic signed [ADC_WIDTH-1:0]       mem [DEPTH];      // capture buffer
   logic [digdar_pkg::REGION_LSB-1:0] ofs;
   logic [31:0]                       count_q;
   logic [BUF_AW:0]                   cap_len;          // samples to take, 1..DEPTH
   logic [BUF_AW-1:0]                 wr_addr_q;
   logic                              wr_en;
   logic                              buf_hit;
   logic                              done;
   digdar_pkg::scope_state_e          state_q;

   assign ofs     = sys_addr_i[digdar_pkg::REGION_LSB-1:0];
   assign armed_o = (state_q == digdar_pkg::sc_armed);
   assign done    = (state_q == digdar_pkg::sc_done);
   assign buf_hit = ofs[digdar_pkg::REGION_LSB-1:BUF_AW+2] ==
                    digdar_pkg::SC_OFS_BUF[digdar_pkg::REGION_LSB-1:BUF_AW+2];

   // sample 0 is always written, count beyond the RAM is clipped
   always_comb begin
      if (count_q >= DEPTH)
         cap_len = (BUF_AW+1)'(DEPTH);
      else if (count_q == '0)
         cap_len = (BUF_AW+1)'(1);
      else
         cap_len = count_q[BUF_AW:0];
   end

   // trigger cycle writes sample 0, capture state writes the rest
   assign wr_en = (armed_o && trig_i) || (state_q == digdar_pkg::sc_capture);

   //------------------------------------------------------------------------
   // FSM
   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         state_q   <= digdar_pkg::sc_idle;
         wr_addr_q <= '0;
      end else begin
         case (state_q)
            digdar_pkg::sc_armed:
               if (trig_i) begin
                  wr_addr_q <= (BUF_AW)'(1);
                  state_q   <= (cap_len == 1) ? digdar_pkg::sc_done
                                              : digdar_pkg::sc_capture;
               end
            digdar_pkg::sc_capture: begin
               wr_addr_q <= wr_addr_q + 1'b1;
               if ({1'b0, wr_addr_q} + 1'b1 == cap_len)
                  state_q <= digdar_pkg::sc_done;     // last sample written
            end
            default:                                  // idle or done waits for arm
               if (sys_wen_i && ofs == digdar_pkg::SC_OFS_CTRL && sys_wdata_i[0])
                  state_q <= digdar_pkg::sc_armed;
         endcase
      end
   end

   always_ff @(posedge adc_clk)
      if (wr_en)
         mem[armed_o ? '0 : wr_addr_q] <= adc_a_i;

   //------------------------------------------------------------------------
   // register region
   always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
         count_q   <= '0;
         negate_o  <= 1'b0;
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i || sys_ren_i;
         if (sys_wen_i && ofs == digdar_pkg::SC_OFS_COUNT)
            count_q <= sys_wdata_i;
         if (sys_wen_i && ofs == digdar_pkg::SC_OFS_NEGATE)
            negate_o <= sys_wdata_i[0];
      end
   end

   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         if (buf_hit)
            sys_rdata_o <= mem[ofs[BUF_AW+1:2]];            // sign-extended sample
         else begin
            case (ofs)
               digdar_pkg::SC_OFS_CTRL:   sys_rdata_o <= {30'h0, done, armed_o};
               digdar_pkg::SC_OFS_COUNT:  sys_rdata_o <= count_q;
               digdar_pkg::SC_OFS_NEGATE: sys_rdata_o <= {31'h0, negate_o};
               default:                   sys_rdata_o <= '0;
            endcase
         end
      end
   end

   // capture never runs past the clipped length
   a_wr_addr_range: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (state_q == digdar_pkg::sc_capture) |-> ({1'b0, wr_addr_q} < cap_len));

endmodule

`default_nettype wire

// File: design/digdar_top.sv
// digdar_top: frontend, bus decoder, housekeeping, radar trigger and scope
`timescale 1ns/10ps
`default_nettype none

module digdar_top #(
   parameter int ADC_WIDTH = 14,
   parameter int BUF_AW    = 10                      // 1024-sample capture
) (
   input  wire                            adc_clk,
   input  wire                            rst_n_i,
   input  wire  [ADC_WIDTH-1:0]           adc_dat_a_i,
   input  wire  [ADC_WIDTH-1:0]           adc_dat_b_i,
   input  wire  [digdar_pkg::SYS_AW-1:0]  sys_addr_i,
   input  wire  [digdar_pkg::SYS_DW-1:0]  sys_wdata_i,
   input  wire                            sys_wen_i,
   input  wire                            sys_ren_i,
   output logic [digdar_pkg::SYS_DW-1:0]  sys_rdata_o,
   output logic                           sys_ack_o,
   output logic                           sys_err_o,
   output logic [7:0]                     led_o
);

   logic signed [ADC_WIDTH-1:0]      adc_a;
   logic signed [ADC_WIDTH-1:0]      adc_b;
   logic                             negate;
   logic                             armed;
   logic                             radar_trig;
   logic                             hk_wen;
   logic                             hk_ren;
   logic                             hk_ack;
   logic                             sc_wen;
   logic                             sc_ren;
   logic                             sc_ack;
   logic                             dd_wen;
   logic                             dd_ren;
   logic                             dd_ack;
   logic [digdar_pkg::SYS_DW-1:0]    hk_rdata;
   logic [digdar_pkg::SYS_DW-1:0]    sc_rdata;
   logic [digdar_pkg::SYS_DW-1:0]    dd_rdata;

   //------------------------------------------------------------------------
   // sample path
   adc_frontend #(.ADC_WIDTH(ADC_WIDTH)) i_frontend (
      .adc_clk, .rst_n_i, .adc_dat_a_i, .adc_dat_b_i,
      .negate_i (negate),
      .adc_a_o  (adc_a),
      .adc_b_o  (adc_b)
   );

   //------------------------------------------------------------------------
   // bus
   sys_bus_decoder i_decoder (
      .adc_clk, .rst_n_i, .sys_addr_i, .sys_wen_i, .sys_ren_i,
      .hk_rdata_i (hk_rdata), .hk_ack_i (hk_ack),
      .sc_rdata_i (sc_rdata), .sc_ack_i (sc_ack),
      .dd_rdata_i (dd_rdata), .dd_ack_i (dd_ack),
      .hk_wen_o   (hk_wen),   .hk_ren_o (hk_ren),
      .sc_wen_o   (sc_wen),   .sc_ren_o (sc_ren),
      .dd_wen_o   (dd_wen),   .dd_ren_o (dd_ren),
      .sys_rdata_o, .sys_ack_o, .sys_err_o
   );

   hk_regs i_hk (
      .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
      .sys_wen_i   (hk_wen),   .sys_ren_i (hk_ren),
      .sys_rdata_o (hk_rdata), .sys_ack_o (hk_ack),
      .led_o
   );

   radar_trigger #(.ADC_WIDTH(ADC_WIDTH)) i_digdar (
      .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
      .adc_b_i     (adc_b),
      .armed_i     (armed),      // gates crossings
      .trig_o      (radar_trig),
      .sys_wen_i   (dd_wen),   .sys_ren_i (dd_ren),
      .sys_rdata_o (dd_rdata), .sys_ack_o (dd_ack)
   );

   scope_capture #(.ADC_WIDTH(ADC_WIDTH), .BUF_AW(BUF_AW)) i_scope (
      .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
      .adc_a_i     (adc_a),
      .trig_i      (radar_trig),
      .armed_o     (armed),
      .negate_o    (negate),
      .sys_wen_i   (sc_wen),   .sys_ren_i (sc_ren),
      .sys_rdata_o (sc_rdata), .sys_ack_o (sc_ack)
   );

endmodule

`default_nettype wire

// File: sim/tb_digdar.sv
// tb_digdar: clock, reset, random ADC stimulus, bus tasks, sample model and checks
`timescale 1ns/10ps
`default_nettype none

module tb_digdar;

   localparam int ADC_WIDTH   = 14;
   localparam int HIST_DEPTH  = 32768;
   localparam int BUS_TIMEOUT = 8;              // negedges to wait for an ack
   localparam int DONE_POLLS  = 1000;           // CTRL reads before giving up
   localparam int MODE_RANDOM = 0;              // channel B anywhere
   localparam int MODE_BELOW  = 1;              // channel B under the threshold
   localparam int MODE_ABOVE  = 2;              // channel B at or over it

   logic                 adc_clk;
   logic                 rst_n_i;
   logic [ADC_WIDTH-1:0] adc_dat_a_i;
   logic [ADC_WIDTH-1:0] adc_dat_b_i;
   logic [31:0]          sys_addr_i;
   logic [31:0]          sys_wdata_i;
   logic                 sys_wen_i;
   logic                 sys_ren_i;
   logic [31:0]          sys_rdata_o;
   logic                 sys_ack_o;
   logic                 sys_err_o;
   logic [7:0]           led_o;

   integer               seed = 32'h3c18;
   int                   errors = 0;
   int                   timeouts = 0;
   int                   exp_trig = 0;      // captures completed so far
   int                   thresh;            // signed threshold for channel B
   int                   b_mode;
   int                   last_mode = MODE_RANDOM;
   int                   cyc = 0;           // stimulus cycle number
   int                   cross_cyc = 0;     // cycle of the forced crossing
   int                   b_val;
   logic [ADC_WIDTH-1:0] a_raw;
   logic [ADC_WIDTH-1:0] hist_a [HIST_DEPTH];   // raw channel A per cycle

   digdar_top #(.ADC_WIDTH(ADC_WIDTH), .BUF_AW(10)) dut0 (
      .adc_clk, .rst_n_i, .adc_dat_a_i, .adc_dat_b_i,
      .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
      .sys_rdata_o, .sys_ack_o, .sys_err_o, .led_o
   );

   initial begin
      adc_clk = 1'b0;
      forever #2 adc_clk = ~adc_clk;            // 250 MHz
   end

   // -------------------------------------------------------------------------
   // reference model where offset binary code v stands for v - 2^(N-1)
   function automatic int offset_to_signed(input logic [ADC_WIDTH-1:0] raw);
      return int'(raw) - (1 << (ADC_WIDTH-1));
   endfunction

   function automatic int negate_sat(input int v);
      if (v == -(1 << (ADC_WIDTH-1)))
         return (1 << (ADC_WIDTH-1)) - 1;       // no positive twin so clamp
      return -v;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [2:0] region, input logic [19:0] ofs);
      return {9'h0, region, ofs};
   endfunction

   // -------------------------------------------------------------------------
   // ADC stimulus with one new sample pair per cycle
   always @(posedge adc_clk) begin
      a_raw = $random(seed);
      if (($random(seed) & 7) == 0)
         a_raw = '0;                            // most negative code exercises the clamp
      case (b_mode)
         MODE_BELOW: b_val = thresh - 1 - ($random(seed) & 32'hfff);
         MODE_ABOVE: b_val = thresh + ($random(seed) & 32'hff);
         default:    b_val = ($random(seed) & 32'h3fff) - (1 << (ADC_WIDTH-1));
      endcase
      if (b_mode == MODE_ABOVE && last_mode != MODE_ABOVE)
         cross_cyc = cyc;                       // first cycle over the threshold
      last_mode = b_mode;
      hist_a[cyc % HIST_DEPTH] = a_raw;
      adc_dat_a_i <= a_raw;
      adc_dat_b_i <= ADC_WIDTH'(b_val + (1 << (ADC_WIDTH-1)));
      cyc = cyc + 1;
   end

   // -------------------------------------------------------------------------
   // one-cycle bus pulse with its ack expected exactly one cycle later
   task automatic run_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int   waited;
      logic exp_err;
      logic [2:0] region;
      region  = addr[digdar_pkg::REGION_MSB:digdar_pkg::REGION_LSB];
      exp_err = !(region == digdar_pkg::region_hk || region == digdar_pkg::region_scope ||
                  region == digdar_pkg::region_digdar);
      @(posedge adc_clk);
      sys_addr_i  <= addr;
      sys_wdata_i <= wdata;
      sys_wen_i   <= wr;
      sys_ren_i   <= !wr;
      @(negedge adc_clk);
      if (sys_ack_o !== 1'b0) begin
         errors++;
         $display("Error %0t: ack during the pulse for %h", $time, addr);
      end
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;
      sys_ren_i <= 1'b0;
      @(negedge adc_clk);
      waited = 0;
      while (sys_ack_o !== 1'b1 && waited < BUS_TIMEOUT) begin
         waited++;
         @(negedge adc_clk);
      end
      rdata = sys_rdata_o;
      if (sys_ack_o !== 1'b1) begin
         timeouts++;
         $display("bus access at address %h was never acknowledged", addr);
      end else begin
         if (waited != 0) begin
            errors++;
            $display("Error %0t: ack %0d cycles late for %h", $time, waited, addr);
         end
         if (sys_err_o !== exp_err) begin
            errors++;
            $display("Error %0t: err %b for %h, expected %b", $time, sys_err_o, addr, exp_err);
         end
         @(negedge adc_clk);
         if (sys_ack_o !== 1'b0) begin
            errors++;
            $display("Error %0t: ack held past one cycle for %h", $time, addr);
         end
      end
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] ignored;
      run_access(1'b1, addr, data, ignored);
   endtask

   task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
      run_access(1'b0, addr, 32'h0, data);
   endtask

   task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      read_reg(addr, data);
      if (data !== exp) begin
         errors++;
         $display("Error %0t: read %h from %h, expected %h", $time, data, addr, exp);
      end
   endtask

   // -------------------------------------------------------------------------
   // one armed capture with the buffer compared against the converted history
   task automatic check_capture(input logic neg);
      int          n_samp;
      int          dly;
      int          lead;
      int          polls;
      int          exp_val;
      logic [31:0] ctrl;
      logic [31:0] data;
      expect_read(reg_addr(digdar_pkg::region_digdar, digdar_pkg::DD_OFS_TRIG_CNT), exp_trig);
      n_samp = ($random(seed) & 32'hff) + 1;
      dly    = $random(seed) & 32'h1f;
      lead   = 8 + ($random(seed) & 32'h0f);
      write_reg(reg_addr(digdar_pkg::region_digdar, digdar_pkg::DD_OFS_DELAY), dly);
      write_reg(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_COUNT), n_samp);
      write_reg(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_NEGATE), neg);
      @(posedge adc_clk);
      b_mode <= MODE_BELOW;                       // quiet channel B before arming
      repeat (lead) @(posedge adc_clk);
      write_reg(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_CTRL), 32'h1);
      expect_read(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_CTRL), 32'h1);
      repeat (lead) @(posedge adc_clk);
      b_mode <= MODE_ABOVE;
      repeat (2) @(posedge adc_clk);
      b_mode <= MODE_RANDOM;                      // later crossings land in the delay
      polls = 0;
      ctrl  = '0;
      while (ctrl[1] !== 1'b1 && polls < DONE_POLLS) begin
         read_reg(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_CTRL), ctrl);
         polls++;
      end
      if (ctrl[1] !== 1'b1) begin
         timeouts++;
         $display("scope never reported its capture as done");
      end else begin
         if (ctrl !== 32'h2) begin
            errors++;
            $display("Error %0t: CTRL %h after capture, expected 2", $time, ctrl);
         end
         for (int i = 0; i < n_samp; i++) begin
            exp_val = offset_to_signed(hist_a[(cross_cyc + 1 + dly + i) % HIST_DEPTH]);
            if (neg)
               exp_val = negate_sat(exp_val);
            read_reg(reg_addr(digdar_pkg::region_scope, digdar_pkg::SC_OFS_BUF + 20'(4 * i)),
                     data);
            if (data !== 32'(exp_val)) begin
               errors++;
               $display("Error %0t: sample %0d is %h, expected %h", $time, i, data,
                        32'(exp_val));
            end
         end
      end
      exp_trig++;
      expect_read(reg_addr(digdar_pkg::region_digdar, digdar_pkg::DD_OFS_TRIG_CNT), exp_trig);
   endtask

   // -------------------------------------------------------------------------
   // main sequence
   initial begin
      logic [7:0] led_val;
      rst_n_i       = 1'b0;
      adc_dat_a_i   = '0;
      adc_dat_b_i   = '0;
      sys_addr_i    = '0;
      sys_wdata_i   = '0;
      sys_wen_i     = 1'b0;
      sys_ren_i     = 1'b0;
      b_mode        = MODE_RANDOM;
      thresh        = 1000 + ($random(seed) & 1023);
      repeat (16) @(posedge adc_clk);
      rst_n_i <= 1'b1;
      @(negedge adc_clk);
      if (sys_ack_o !== 1'b0 || sys_err_o !== 1'b0 || led_o !== 8'h0) begin
         errors++;
         $display("Error %0t: outputs not idle after reset", $time);
      end

      // housekeeping region
      expect_read(reg_addr(digdar_pkg::region_hk, digdar_pkg::HK_OFS_ID),
                  digdar_pkg::HK_ID_VALUE);
      repeat (4) begin
         led_val = 8'($random(seed));
         write_reg(reg_addr(digdar_pkg::region_hk, digdar_pkg::HK_OFS_LED), led_val);
         if (led_o !== led_val) begin
            errors++;
            $display("Error %0t: led_o %h, expected %h", $time, led_o, led_val);
         end
         expect_read(reg_addr(digdar_pkg::region_hk, digdar_pkg::HK_OFS_LED), {24'h0, led_val});
      end
      expect_read(reg_addr(digdar_pkg::region_hk, 20'h8), 32'h0);   // hole reads zero

      // unmapped regions answer with err and zero data
      for (int r = 0; r < 8; r++) begin
         if (r != 0 && r != 1 && r != 6)
            expect_read(reg_addr(3'(r), 20'h0), 32'h0);
      end
      write_reg(reg_addr(3'd5, 20'h4), 32'hffff_ffff);

      // threshold first and unarmed crossings must not count
      write_reg(reg_addr(digdar_pkg::region_digdar, digdar_pkg::DD_OFS_THRESH), thresh);
      expect_read(reg_addr(digdar_pkg::region_digdar, digdar_pkg::DD_OFS_THRESH), thresh);
      for (int run = 0; run < 6; run++) begin
         repeat (100) @(posedge adc_clk);            // free-running channel B
         check_capture(run >= 3);
      end

      $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
design/digdar_pkg.sv
design/adc_frontend.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/radar_trigger.sv
design/scope_capture.sv
design/digdar_top.sv
sim/tb_digdar.sv

// File: Bender.yml
package:
  name: digdar

sources:
  # package first, then the blocks, top level last
  - design/digdar_pkg.sv
  - design/adc_frontend.sv
  - design/sys_bus_decoder.sv
  - design/hk_regs.sv
  - design/radar_trigger.sv
  - design/scope_capture.sv
  - design/digdar_top.sv

  - target: simulation
    files:
      - sim/tb_digdar.sv
